/* src/sa_cfg.svh */
`ifndef SA_CFG_SVH
`define SA_CFG_SVH

// Array geometry
`define SA_ROWS 4
`define SA_COLS 4

// Datapath widths
`define SA_ELEM_W 8   // Signed operand element
`define SA_ACC_W 32   // Accumulator, sized so that no sum overflows

// Problem limits
`define SA_MAX_N 64   // Largest matrix dimension, sets coordinate width
`define SA_MAX_K 64   // Largest block depth in beats

`endif

/* src/sa_pkg.sv */
`include "sa_cfg.svh"

package sa_pkg;

  // One operand element as it enters the array
  typedef logic signed [`SA_ELEM_W-1:0] elem_t;

  // Running sum held in each PE
  typedef logic signed [`SA_ACC_W-1:0] acc_t;

  // Absolute row or column in the output matrix
  typedef logic [$clog2(`SA_MAX_N)-1:0] coord_t;

  // Beat counter, must reach SA_MAX_K itself
  typedef logic [$clog2(`SA_MAX_K+1)-1:0] kcnt_t;

endpackage

/* src/sa_ifs.sv */
`include "sa_cfg.svh"

// Skewed operand wavefronts into the PE grid
interface sa_wave_if import sa_pkg::*; ();

  elem_t [`SA_ROWS-1:0]         a_wave;      // Row i delayed by i
  elem_t [`SA_COLS-1:0]         b_wave;      // Column j delayed by j
  logic  [`SA_ROWS+`SA_COLS-1:0] wave_valid; // Row flags low, column flags high
  logic                         clear;       // First wavefront of a block

  modport source (output a_wave, b_wave, wave_valid, clear);
  modport sink   (input  a_wave, b_wave, wave_valid, clear);

endinterface

// Block completion handshake between skewer and coordinator
interface sa_done_if import sa_pkg::*; ();

  logic   done;        // All wavefronts flushed through the grid
  coord_t pos_row;     // Base row of the finished block
  coord_t pos_col;     // Base column of the finished block
  logic   coord_idle;  // Falls on capture

  modport source (output done, pos_row, pos_col, input coord_idle);
  modport sink   (input done, pos_row, pos_col, output coord_idle);

endinterface

/* src/operand_skewer.sv */
`include "sa_cfg.svh"

module operand_skewer import sa_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 op_valid,
  output logic                 op_ready,
  input  logic                 op_last,
  input  elem_t [`SA_ROWS-1:0] op_a,
  input  elem_t [`SA_COLS-1:0] op_b,
  input  coord_t               pos_row,
  input  coord_t               pos_col,
  sa_wave_if.source            wave,
  sa_done_if.source            dn
);

  localparam int ROWS  = `SA_ROWS;
  localparam int COLS  = `SA_COLS;
  localparam int LANES = ROWS + COLS;   // Rows first, then columns
  localparam int FLUSH = ROWS + COLS;   // Cycles from last beat to done
  localparam int FW    = $clog2(FLUSH);

  logic          run;           // Set one cycle after reset
  logic          flushing;      // Last beat taken, wavefronts still moving
  logic [FW-1:0] flush_cnt;
  kcnt_t         beat_cnt;      // Beats taken in the current block
  logic          coord_idle_q;  // For the falling edge of coord_idle
  logic          accept;
  logic          first_beat;

  elem_t [LANES-1:0] lane_in;
  elem_t [LANES-1:0] lane_out;
  logic  [LANES-1:0] lane_vld;

  // One block in flight, next one waits for capture
  assign op_ready   = run & ~flushing & ~dn.done;
  assign accept     = op_valid & op_ready;
  assign first_beat = (beat_cnt == '0);
  assign lane_in    = {op_b, op_a};

  always_ff @(posedge clk) begin
    if (reset) begin
      run          <= 1'b0;
      flushing     <= 1'b0;
      flush_cnt    <= '0;
      beat_cnt     <= '0;
      coord_idle_q <= 1'b1;
      dn.done      <= 1'b0;
      wave.clear   <= 1'b0;
    end else begin
      run          <= 1'b1;
      coord_idle_q <= dn.coord_idle;
      wave.clear   <= accept & first_beat;  // Lines up with lane 0 stage 0
      if (accept) begin
        beat_cnt <= op_last ? '0 : beat_cnt + 1'b1;
      end
      if (accept & op_last) begin
        flushing  <= 1'b1;
        flush_cnt <= '0;
      end else if (flushing) begin
        flush_cnt <= flush_cnt + 1'b1;
        // Last PE has updated and its forwarded valid is gone
        if (flush_cnt == FW'(FLUSH - 1)) begin
          flushing <= 1'b0;
          dn.done  <= 1'b1;
        end
      end
      if (dn.done & coord_idle_q & ~dn.coord_idle) begin
        dn.done <= 1'b0;  // Coordinator has its copy
      end
    end
  end

  // Base position held until the next block starts
  always_ff @(posedge clk) begin
    if (accept & first_beat) begin
      dn.pos_row <= pos_row;
      dn.pos_col <= pos_col;
    end
  end

  // Lane n gets one input register plus its row or column offset
  for (genvar n = 0; n < LANES; n++) begin : g_lane
    localparam int DEPTH = (n < ROWS) ? n : n - ROWS;

    elem_t sr_data [DEPTH+1];
    logic  sr_vld  [DEPTH+1];

    always_ff @(posedge clk) begin
      sr_data[0] <= lane_in[n];
      for (int d = 1; d <= DEPTH; d++) begin
        sr_data[d] <= sr_data[d-1];
      end
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int d = 0; d <= DEPTH; d++) begin
          sr_vld[d] <= 1'b0;
        end
      end else begin
        sr_vld[0] <= accept;  // Valid walks beside its data
        for (int d = 1; d <= DEPTH; d++) begin
          sr_vld[d] <= sr_vld[d-1];
        end
      end
    end

    assign lane_out[n] = sr_data[DEPTH];
    assign lane_vld[n] = sr_vld[DEPTH];
  end

  assign wave.a_wave     = lane_out[ROWS-1:0];
  assign wave.b_wave     = lane_out[LANES-1:ROWS];
  assign wave.wave_valid = lane_vld;

endmodule

/* src/mac_pe.sv */
module mac_pe import sa_pkg::*; #(
  parameter int ROW_IDX = 0,  // Grid position, for bound checks
  parameter int COL_IDX = 0
)(
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,        // Start of a new block
  input  elem_t a_in,         // From the left
  input  elem_t b_in,         // From above
  input  logic  a_valid_in,
  input  logic  b_valid_in,
  output elem_t a_out,        // To the right
  output elem_t b_out,        // Downward
  output logic  a_valid_out,
  output logic  b_valid_out,
  output acc_t  acc,
  output logic  busy          // Something still passing through
);

  logic fire;
  acc_t prod;

  assign fire = a_valid_in & b_valid_in;
  assign prod = acc_t'(a_in) * acc_t'(b_in);  // Sign extended before multiply

  // Clear drops the old block's sum, keeps this cycle's product
  always_ff @(posedge clk) begin
    if (clear) begin
      acc <= fire ? prod : '0;
    end else if (fire) begin
      acc <= acc + prod;
    end
  end

  always_ff @(posedge clk) begin
    a_out <= a_in;
    b_out <= b_in;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      a_valid_out <= 1'b0;
      b_valid_out <= 1'b0;
    end else begin
      a_valid_out <= a_valid_in;
      b_valid_out <= b_valid_in;
    end
  end

  assign busy = a_valid_out | b_valid_out;

endmodule

/* src/output_coordinator.sv */
`include "sa_cfg.svh"

module output_coordinator import sa_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  sa_done_if.sink                      dn,
  input  acc_t [`SA_ROWS*`SA_COLS-1:0] pe_acc,   // Row-major, PE(i,j) at i*COLS+j
  input  logic [`SA_ROWS*`SA_COLS-1:0] pe_busy,
  output logic                         res_valid,
  input  logic                         res_ready,
  output logic                         res_last,
  output acc_t                         res_data,
  output coord_t                       res_row,
  output coord_t                       res_col
);

  localparam int ROWS = `SA_ROWS;
  localparam int COLS = `SA_COLS;
  localparam int NPE  = ROWS * COLS;
  localparam int RW   = (ROWS > 1) ? $clog2(ROWS) : 1;
  localparam int CW   = (COLS > 1) ? $clog2(COLS) : 1;
  localparam int IW   = (NPE > 1) ? $clog2(NPE) : 1;

  logic          streaming;   // Results being handed out
  logic          read_array;  // Already captured this done
  logic          array_idle;
  logic          capture;
  logic [RW-1:0] row_idx;
  logic [CW-1:0] col_idx;
  logic          row_end;
  logic          col_end;
  logic [IW-1:0] flat_idx;

  acc_t [NPE-1:0] cap_acc;    // Snapshot of every accumulator
  coord_t         base_row;
  coord_t         base_col;

  assign array_idle = ~|pe_busy;
  // Done alone is not enough, the grid must also be quiet
  assign capture    = dn.done & array_idle & ~streaming & ~read_array;
  assign row_end    = (row_idx == RW'(ROWS - 1));
  assign col_end    = (col_idx == CW'(COLS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      streaming  <= 1'b0;
      read_array <= 1'b0;
      row_idx    <= '0;
      col_idx    <= '0;
    end else begin
      if (capture) begin
        streaming  <= 1'b1;
        read_array <= 1'b1;
        row_idx    <= '0;
        col_idx    <= '0;
      end else if (!dn.done) begin
        read_array <= 1'b0;  // Skewer saw the capture, arm for next block
      end
      if (streaming & res_ready) begin
        if (col_end) begin
          col_idx <= '0;
          if (row_end) begin
            streaming <= 1'b0;  // Final result gone
          end else begin
            row_idx <= row_idx + 1'b1;
          end
        end else begin
          col_idx <= col_idx + 1'b1;
        end
      end
    end
  end

  // Grid is free to start the next block once this is taken
  always_ff @(posedge clk) begin
    if (capture) begin
      cap_acc  <= pe_acc;
      base_row <= dn.pos_row;
      base_col <= dn.pos_col;
    end
  end

  assign flat_idx = IW'(row_idx) * IW'(COLS) + IW'(col_idx);

  // Everything below comes from registers, stays put while stalled
  assign res_valid     = streaming;
  assign res_last      = streaming & row_end & col_end;
  assign res_data      = cap_acc[flat_idx];
  assign res_row       = base_row + coord_t'(row_idx);  // Base plus PE offset
  assign res_col       = base_col + coord_t'(col_idx);
  assign dn.coord_idle = ~streaming;

endmodule

/* src/systolic_tile.sv */
`include "sa_cfg.svh"

module systolic_tile import sa_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 op_valid,
  output logic                 op_ready,
  input  logic                 op_last,
  input  elem_t [`SA_ROWS-1:0] op_a,     // Column slice of A
  input  elem_t [`SA_COLS-1:0] op_b,     // Row slice of B
  input  coord_t               pos_row,
  input  coord_t               pos_col,
  output logic                 res_valid,
  input  logic                 res_ready,
  output logic                 res_last,
  output acc_t                 res_data,
  output coord_t               res_row,
  output coord_t               res_col
);

  localparam int ROWS = `SA_ROWS;
  localparam int COLS = `SA_COLS;

  sa_wave_if wave ();
  sa_done_if dn ();

  // Forwarded operands, indexed by the PE that drives them
  elem_t a_fwd  [ROWS][COLS];
  elem_t b_fwd  [ROWS][COLS];
  logic  av_fwd [ROWS][COLS];
  logic  bv_fwd [ROWS][COLS];

  acc_t [ROWS*COLS-1:0] pe_acc;
  logic [ROWS*COLS-1:0] pe_busy;

  operand_skewer skewer_inst (
    .clk      (clk),
    .reset    (reset),
    .op_valid (op_valid),
    .op_ready (op_ready),
    .op_last  (op_last),
    .op_a     (op_a),
    .op_b     (op_b),
    .pos_row  (pos_row),
    .pos_col  (pos_col),
    .wave     (wave),
    .dn       (dn)
  );

  for (genvar i = 0; i < ROWS; i++) begin : g_row
    for (genvar j = 0; j < COLS; j++) begin : g_col
      elem_t a_src;
      elem_t b_src;
      logic  av_src;
      logic  bv_src;

      // Left column fed by the skewer, the rest by the left neighbour
      if (j == 0) begin : g_a_edge
        assign a_src  = wave.a_wave[i];
        assign av_src = wave.wave_valid[i];
      end else begin : g_a_inner
        assign a_src  = a_fwd[i][j-1];
        assign av_src = av_fwd[i][j-1];
      end

      if (i == 0) begin : g_b_edge
        assign b_src  = wave.b_wave[j];
        assign bv_src = wave.wave_valid[ROWS+j];  // Column flags sit above row flags
      end else begin : g_b_inner
        assign b_src  = b_fwd[i-1][j];
        assign bv_src = bv_fwd[i-1][j];
      end

      mac_pe #(
        .ROW_IDX (i),
        .COL_IDX (j)
      ) pe_inst (
        .clk         (clk),
        .reset       (reset),
        .clear       (wave.clear),
        .a_in        (a_src),
        .b_in        (b_src),
        .a_valid_in  (av_src),
        .b_valid_in  (bv_src),
        .a_out       (a_fwd[i][j]),
        .b_out       (b_fwd[i][j]),
        .a_valid_out (av_fwd[i][j]),
        .b_valid_out (bv_fwd[i][j]),
        .acc         (pe_acc[i*COLS+j]),
        .busy        (pe_busy[i*COLS+j])
      );
    end
  end

  output_coordinator coord_inst (
    .clk       (clk),
    .reset     (reset),
    .dn        (dn),
    .pe_acc    (pe_acc),
    .pe_busy   (pe_busy),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_last  (res_last),
    .res_data  (res_data),
    .res_row   (res_row),
    .res_col   (res_col)
  );

endmodule

/* bench/systolic_tile_props.sv */
module systolic_tile_props import sa_pkg::*; (
  input logic   clk,
  input logic   reset,
  input logic   op_valid,
  input logic   op_ready,
  input logic   op_last,
  input logic   res_valid,
  input logic   res_ready,
  input logic   res_last,
  input acc_t   res_data,
  input coord_t res_row,
  input coord_t res_col
);

  // Both streams quiet once a reset edge has passed
  reset_quiet: assert property (@(posedge clk) reset |=> !op_ready && !res_valid)
    else $error("op_ready or res_valid high after a reset cycle");

  // Stalled result holds still
  res_hold: assert property (@(posedge clk) disable iff (reset)
    res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_row)
      && $stable(res_col) && $stable(res_last))
    else $error("Result stream changed while stalled");

  // Next block waits for the capture
  one_in_flight: assert property (@(posedge clk) disable iff (reset)
    op_valid && op_ready && op_last |=> !op_ready)
    else $error("op_ready still high after the last beat of a block");

  // Next capture needs an idle coordinator first
  gap_after_last: assert property (@(posedge clk) disable iff (reset)
    res_valid && res_ready && res_last |=> !res_valid)
    else $error("res_valid still high right after the final result of a block");

endmodule

/* bench/systolic_tile_tb.sv */
`include "sa_cfg.svh"

module systolic_tile_tb import sa_pkg::*; ();

  localparam int ROWS = `SA_ROWS;
  localparam int COLS = `SA_COLS;
  localparam int NPE  = ROWS * COLS;
  localparam int MAXK = `SA_MAX_K;
  localparam int NBLK = 7;
  localparam int BEAT_TIMEOUT   = 2000;  // Cycles waiting for op_ready
  localparam int RESULT_TIMEOUT = 2000;  // Cycles without a result transfer

  // One row per block of work
  typedef struct packed {
    int     k;          // Beats in the block
    coord_t row;        // Base row
    coord_t col;        // Base column
    int     stall_pct;  // Chance of res_ready low, in percent
  } block_row_t;

  logic                clk = 1'b0;
  logic                reset;
  logic                op_valid;
  logic                op_ready;
  logic                op_last;
  elem_t [ROWS-1:0]    op_a;
  elem_t [COLS-1:0]    op_b;
  coord_t              pos_row;
  coord_t              pos_col;
  logic                res_valid;
  logic                res_ready;
  logic                res_last;
  acc_t                res_data;
  coord_t              res_row;
  coord_t              res_col;

  integer     seed;
  block_row_t block_table [NBLK];
  elem_t      a_all [NBLK][ROWS][MAXK];  // A columns per beat
  elem_t      b_all [NBLK][MAXK][COLS];  // B rows per beat

  // Expected results in row-major order, all blocks back to back
  acc_t   exp_data_q [$];
  coord_t exp_row_q  [$];
  coord_t exp_col_q  [$];

  int data_errors     = 0;
  int coord_errors    = 0;
  int flag_errors     = 0;
  int protocol_errors = 0;
  int timeout_errors  = 0;
  int total_errors;

  always #2 clk = ~clk;

  systolic_tile systolic_tile_inst (
    .clk       (clk),
    .reset     (reset),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .op_last   (op_last),
    .op_a      (op_a),
    .op_b      (op_b),
    .pos_row   (pos_row),
    .pos_col   (pos_col),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_last  (res_last),
    .res_data  (res_data),
    .res_row   (res_row),
    .res_col   (res_col)
  );

  bind systolic_tile systolic_tile_props props_inst (
    .clk       (clk),
    .reset     (reset),
    .op_valid  (op_valid),
    .op_ready  (op_ready),
    .op_last   (op_last),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_last  (res_last),
    .res_data  (res_data),
    .res_row   (res_row),
    .res_col   (res_col)
  );

  task automatic compare_acc(input acc_t got, input acc_t want, input string what);
    if (got !== want) begin
      data_errors++;
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic compare_coord(input coord_t got, input coord_t want, input string what);
    if (got !== want) begin
      coord_errors++;
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic compare_bit(input logic got, input logic want, input string what);
    if (got !== want) begin
      flag_errors++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic load_table;
    block_table[0] = '{k: 1,    row: coord_t'(0),  col: coord_t'(0),  stall_pct: 0};
    block_table[1] = '{k: MAXK, row: coord_t'(4),  col: coord_t'(8),  stall_pct: 0};  // Clear check
    block_table[2] = '{k: 5,    row: coord_t'(60), col: coord_t'(60), stall_pct: 50};
    block_table[3] = '{k: 16,   row: coord_t'(12), col: coord_t'(36), stall_pct: 30};
    block_table[4] = '{k: 2,    row: coord_t'(20), col: coord_t'(4),  stall_pct: 70};
    block_table[5] = '{k: 8,    row: coord_t'(0),  col: coord_t'(48), stall_pct: 10};
    block_table[6] = '{k: 3,    row: coord_t'(32), col: coord_t'(16), stall_pct: 0};
  endtask

  // Random operands and the matrix product they should give
  task automatic build_block(input int b);
    int sum;
    for (int k = 0; k < block_table[b].k; k++) begin
      for (int i = 0; i < ROWS; i++) begin
        a_all[b][i][k] = elem_t'($random(seed));
      end
      for (int j = 0; j < COLS; j++) begin
        b_all[b][k][j] = elem_t'($random(seed));
      end
    end
    for (int i = 0; i < ROWS; i++) begin
      for (int j = 0; j < COLS; j++) begin
        sum = 0;
        for (int k = 0; k < block_table[b].k; k++) begin
          sum += int'(a_all[b][i][k]) * int'(b_all[b][k][j]);  // Signed elements
        end
        exp_data_q.push_back(acc_t'(sum));
        exp_row_q.push_back(coord_t'(int'(block_table[b].row) + i));
        exp_col_q.push_back(coord_t'(int'(block_table[b].col) + j));
      end
    end
  endtask

  // Called 1 unit after a rising edge, returns at the same point
  task automatic send_beat(input int b, input int k, output bit ok);
    int waited;
    waited   = 0;
    ok       = 1'b1;
    op_valid = 1'b1;
    op_last  = (k == block_table[b].k - 1);
    for (int i = 0; i < ROWS; i++) begin
      op_a[i] = a_all[b][i][k];
    end
    for (int j = 0; j < COLS; j++) begin
      op_b[j] = b_all[b][k][j];
    end
    // Later beats carry junk, the DUT keeps the first beat's position
    pos_row = (k == 0) ? block_table[b].row : ~block_table[b].row;
    pos_col = (k == 0) ? block_table[b].col : ~block_table[b].col;
    @(negedge clk);
    while (!op_ready) begin
      waited++;
      if (waited >= BEAT_TIMEOUT) begin
        timeout_errors++;
        $display("Timeout at %0t: op_ready stayed low for block %0d beat %0d", $time, b, k);
        ok = 1'b0;
        return;
      end
      @(negedge clk);
    end
    @(posedge clk);  // Beat taken here
    #1;
  endtask

  task automatic send_blocks;
    bit ok;
    ok = 1'b1;
    for (int b = 0; b < NBLK && ok; b++) begin
      for (int k = 0; k < block_table[b].k && ok; k++) begin
        send_beat(b, k, ok);
      end
    end
    op_valid = 1'b0;
    op_last  = 1'b0;
  endtask

  // Watches both streams, sampled at the falling edge
  task automatic collect_results;
    int   total;
    int   got;
    int   idle;
    int   roll;
    int   blocks_sent;
    int   blocks_captured;
    bit   in_block;
    bit   last_due;
    acc_t want_data;
    coord_t want_row;
    coord_t want_col;
    total           = exp_data_q.size();
    got             = 0;
    idle            = 0;
    blocks_sent     = 0;
    blocks_captured = 0;
    in_block        = 1'b0;
    while (got < total) begin
      roll      = int'($unsigned($random(seed)) % 32'd100);
      res_ready = (roll >= block_table[got / NPE].stall_pct);
      @(negedge clk);
      if (res_valid && !in_block) begin
        if (blocks_captured >= blocks_sent) begin
          protocol_errors++;
          $display("Results appeared at %0t with no finished block waiting", $time);
        end
        blocks_captured++;
        in_block = 1'b1;
      end
      if (op_ready && blocks_captured != blocks_sent) begin
        protocol_errors++;
        $display("op_ready high at %0t before the previous block was captured", $time);
      end
      if (op_valid && op_ready && op_last) begin
        blocks_sent++;
      end
      if (res_valid && res_ready) begin
        want_data = exp_data_q.pop_front();
        want_row  = exp_row_q.pop_front();
        want_col  = exp_col_q.pop_front();
        last_due  = ((got % NPE) == NPE - 1);
        compare_acc(res_data, want_data, $sformatf("res_data of result %0d", got));
        compare_coord(res_row, want_row, $sformatf("res_row of result %0d", got));
        compare_coord(res_col, want_col, $sformatf("res_col of result %0d", got));
        compare_bit(res_last, last_due, $sformatf("res_last of result %0d", got));
        if (last_due) begin
          in_block = 1'b0;
        end
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle >= RESULT_TIMEOUT) begin
          timeout_errors++;
          $display("Timeout at %0t: no result for %0d cycles, %0d of %0d received",
                   $time, RESULT_TIMEOUT, got, total);
          break;
        end
      end
      @(posedge clk);
      #1;
    end
    res_ready = 1'b0;
  endtask

  initial begin
    seed      = 32'hf94f_26d7;
    reset     = 1'b1;
    op_valid  = 1'b0;
    op_last   = 1'b0;
    op_a      = '0;
    op_b      = '0;
    pos_row   = '0;
    pos_col   = '0;
    res_ready = 1'b0;
    load_table();
    for (int b = 0; b < NBLK; b++) begin
      build_block(b);
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    fork
      send_blocks();
      collect_results();
    join
    repeat (4) @(posedge clk);  // Let the bound checks see the tail
    total_errors = data_errors + coord_errors + flag_errors + protocol_errors + timeout_errors;
    $display("Errors: data %0d coord %0d flag %0d protocol %0d timeout %0d",
             data_errors, coord_errors, flag_errors, protocol_errors, timeout_errors);
    if (total_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* systolic_tile.f */
+incdir+src
src/sa_pkg.sv
src/sa_ifs.sv
src/operand_skewer.sv
src/mac_pe.sv
src/output_coordinator.sv
src/systolic_tile.sv
bench/systolic_tile_props.sv
bench/systolic_tile_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the systolic tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f systolic_tile.f \
  --top-module systolic_tile_tb -o systolic_tile_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/systolic_tile_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
